/* compile.f */
+incdir+hw
hw/ooo_pkg.sv
hw/result_if.sv
hw/issue_sched.sv
hw/alu_pipe.sv
hw/wb_merge.sv
hw/ooo_core_top.sv
tb/sched_checker.sv
tb/tb_top.sv

/* hw/alu_pipe.sv */
`include "ooo_defines.svh"

module alu_pipe
  import ooo_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_iss_valid,
  input  issue_t                 i_iss,
  input  logic                   i_grant,
  output logic                   o_stall,
  output logic                   o_res_valid,
  output logic [`OOO_RNID_W-1:0] o_res_rnid,
  output logic [`OOO_DATA_W-1:0] o_res_value
);

  logic                   r_valid;
  logic [`OOO_RNID_W-1:0] r_rnid;
  logic [`OOO_DATA_W-1:0] r_value;
  logic [`OOO_DATA_W-1:0] w_result;
  logic                   w_load;

  always_comb begin
    case (i_iss.op)
      OP_ADD:  w_result = i_iss.val1 + i_iss.val2;
      OP_SUB:  w_result = i_iss.val1 - i_iss.val2;
      OP_AND:  w_result = i_iss.val1 & i_iss.val2;
      OP_XOR:  w_result = i_iss.val1 ^ i_iss.val2;
      default: w_result = '0;
    endcase
  end

  // output register free, or leaving this cycle
  assign w_load = ~r_valid | i_grant;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_valid <= 1'b0;
    end else if (w_load) begin
      r_valid <= i_iss_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_load && i_iss_valid) begin
      r_rnid  <= i_iss.rnid;
      r_value <= w_result;
    end
  end

  assign o_stall     = r_valid & ~i_grant;  // holding an ungranted result
  assign o_res_valid = r_valid;
  assign o_res_rnid  = r_rnid;
  assign o_res_value = r_value;

endmodule

/* hw/issue_sched.sv */
`include "ooo_defines.svh"

module issue_sched
  import ooo_pkg::*;
(
  input  logic   i_clk,
  input  logic   i_rst_n,
  input  logic   i_disp_valid,
  input  disp_t  i_disp,
  output logic   o_credit,
  result_if.lsn  wake,
  input  logic   i_stall,
  output logic   o_iss_valid,
  output issue_t o_iss
);

  localparam int N     = `OOO_ENTRY_SIZE;
  localparam int PTR_W = $clog2(N);

  logic [N-1:0]     r_vld;
  disp_t            r_ent [N];
  logic [PTR_W-1:0] r_in_ptr;
  logic [PTR_W-1:0] r_out_ptr;   // oldest live entry
  logic             r_credit;

  logic [N-1:0]     w_hit1;
  logic [N-1:0]     w_hit2;
  logic [N-1:0]     w_rdy;
  logic [N-1:0]     w_pick_oh;
  logic             w_pick_valid;
  logic [PTR_W-1:0] w_pick_idx;
  logic [PTR_W-1:0] w_alloc_idx;
  logic [PTR_W-1:0] w_out_next;
  disp_t            w_disp_woke;

  function automatic logic tag_hit(src_t s, logic bus_valid,
                                   logic [`OOO_RNID_W-1:0] bus_rnid);
    return !s.ready && bus_valid && (s.opnd.tag.rnid == bus_rnid);
  endfunction

  // capture the bus value into a waiting operand
  function automatic src_t wake_src(src_t s, logic hit, logic [`OOO_DATA_W-1:0] val);
    src_t r;
    r = s;
    if (hit) begin
      r.ready      = 1'b1;
      r.opnd.value = val;
    end
    return r;
  endfunction

  always_comb begin
    for (int i = 0; i < N; i++) begin
      w_hit1[i] = tag_hit(r_ent[i].src1, wake.valid, wake.rnid);
      w_hit2[i] = tag_hit(r_ent[i].src2, wake.valid, wake.rnid);
      w_rdy[i]  = r_vld[i] & (r_ent[i].src1.ready | w_hit1[i])
                           & (r_ent[i].src2.ready | w_hit2[i]);
    end
  end

  // oldest ready, walking the ring from the out pointer
  always_comb begin
    logic [PTR_W-1:0] idx;
    logic             found;
    found      = 1'b0;
    w_pick_idx = r_out_ptr;
    for (int k = 0; k < N; k++) begin
      idx = r_out_ptr + PTR_W'(k);
      if (!found && w_rdy[idx]) begin
        found      = 1'b1;
        w_pick_idx = idx;
      end
    end
    w_pick_valid = found & ~i_stall;
  end

  assign w_pick_oh = w_pick_valid ? ({{(N-1){1'b0}}, 1'b1} << w_pick_idx) : '0;

  // normally the in pointer itself
  always_comb begin
    logic [PTR_W-1:0] idx;
    logic             found;
    found       = 1'b0;
    w_alloc_idx = r_in_ptr;
    for (int k = 0; k < N; k++) begin
      idx = r_in_ptr + PTR_W'(k);
      if (!found && !r_vld[idx]) begin
        found       = 1'b1;
        w_alloc_idx = idx;
      end
    end
  end

  // skip slots freed by issue
  always_comb begin
    logic [PTR_W-1:0] idx;
    logic [N-1:0]     stay;
    logic             found;
    stay       = r_vld & ~w_pick_oh;
    found      = 1'b0;
    w_out_next = i_disp_valid ? w_alloc_idx : r_in_ptr;  // drained
    for (int k = 0; k < N; k++) begin
      idx = r_out_ptr + PTR_W'(k);
      if (!found && stay[idx]) begin
        found      = 1'b1;
        w_out_next = idx;
      end
    end
  end

  // producer may complete in the dispatch cycle
  always_comb begin
    w_disp_woke      = i_disp;
    w_disp_woke.src1 = wake_src(i_disp.src1, tag_hit(i_disp.src1, wake.valid, wake.rnid),
                                wake.value);
    w_disp_woke.src2 = wake_src(i_disp.src2, tag_hit(i_disp.src2, wake.valid, wake.rnid),
                                wake.value);
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_vld     <= '0;
      r_in_ptr  <= '0;
      r_out_ptr <= '0;
      r_credit  <= 1'b0;
    end else begin
      r_vld <= (r_vld & ~w_pick_oh)
             | (i_disp_valid ? ({{(N-1){1'b0}}, 1'b1} << w_alloc_idx) : '0);
      if (i_disp_valid) begin
        r_in_ptr <= w_alloc_idx + 1'b1;
      end
      r_out_ptr <= w_out_next;
      r_credit  <= w_pick_valid;  // one credit per freed entry
    end
  end

  always_ff @(posedge i_clk) begin
    for (int i = 0; i < N; i++) begin
      if (i_disp_valid && (w_alloc_idx == PTR_W'(i))) begin
        r_ent[i] <= w_disp_woke;
      end else begin
        r_ent[i].src1 <= wake_src(r_ent[i].src1, w_hit1[i], wake.value);
        r_ent[i].src2 <= wake_src(r_ent[i].src2, w_hit2[i], wake.value);
      end
    end
  end

  always_comb begin
    disp_t e;
    e          = r_ent[w_pick_idx];
    o_iss.op   = e.op;
    o_iss.val1 = w_hit1[w_pick_idx] ? wake.value : e.src1.opnd.value;
    o_iss.val2 = w_hit2[w_pick_idx] ? wake.value : e.src2.opnd.value;
    o_iss.rnid = e.rnid;
  end

  assign o_iss_valid = w_pick_valid;
  assign o_credit    = r_credit;

endmodule

/* hw/ooo_core_top.sv */
`include "ooo_defines.svh"

module ooo_core_top
  import ooo_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_disp_valid_0,
  input  disp_t                  i_disp_0,
  input  logic                   i_disp_valid_1,
  input  disp_t                  i_disp_1,
  output logic                   o_credit_0,
  output logic                   o_credit_1,
  output logic                   o_done_valid,
  output logic [`OOO_RNID_W-1:0] o_done_rnid,
  output logic [`OOO_DATA_W-1:0] o_done_value,
  output logic                   o_done_lane
);

  result_if u_res_bus ();

  logic                   w_iss_valid_0;
  issue_t                 w_iss_0;
  logic                   w_stall_0;
  logic                   w_grant_0;
  logic                   w_res_valid_0;
  logic [`OOO_RNID_W-1:0] w_res_rnid_0;
  logic [`OOO_DATA_W-1:0] w_res_value_0;

  logic                   w_iss_valid_1;
  issue_t                 w_iss_1;
  logic                   w_stall_1;
  logic                   w_grant_1;
  logic                   w_res_valid_1;
  logic [`OOO_RNID_W-1:0] w_res_rnid_1;
  logic [`OOO_DATA_W-1:0] w_res_value_1;

  // lane 0
  issue_sched u_sched_0 (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_disp_valid(i_disp_valid_0), .i_disp(i_disp_0), .o_credit(o_credit_0),
    .wake(u_res_bus), .i_stall(w_stall_0),
    .o_iss_valid(w_iss_valid_0), .o_iss(w_iss_0)
  );

  alu_pipe u_alu_0 (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_iss_valid(w_iss_valid_0), .i_iss(w_iss_0),
    .i_grant(w_grant_0), .o_stall(w_stall_0),
    .o_res_valid(w_res_valid_0), .o_res_rnid(w_res_rnid_0), .o_res_value(w_res_value_0)
  );

  // lane 1
  issue_sched u_sched_1 (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_disp_valid(i_disp_valid_1), .i_disp(i_disp_1), .o_credit(o_credit_1),
    .wake(u_res_bus), .i_stall(w_stall_1),
    .o_iss_valid(w_iss_valid_1), .o_iss(w_iss_1)
  );

  alu_pipe u_alu_1 (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_iss_valid(w_iss_valid_1), .i_iss(w_iss_1),
    .i_grant(w_grant_1), .o_stall(w_stall_1),
    .o_res_valid(w_res_valid_1), .o_res_rnid(w_res_rnid_1), .o_res_value(w_res_value_1)
  );

  wb_merge u_merge (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_valid_0(w_res_valid_0), .i_rnid_0(w_res_rnid_0), .i_value_0(w_res_value_0),
    .i_valid_1(w_res_valid_1), .i_rnid_1(w_res_rnid_1), .i_value_1(w_res_value_1),
    .o_grant_0(w_grant_0), .o_grant_1(w_grant_1),
    .bus(u_res_bus)
  );

  // done report taps the wakeup bus
  assign o_done_valid = u_res_bus.valid;
  assign o_done_rnid  = u_res_bus.rnid;
  assign o_done_value = u_res_bus.value;
  assign o_done_lane  = u_res_bus.lane;

endmodule

/* hw/ooo_defines.svh */
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

// entries per lane queue
`define OOO_ENTRY_SIZE 8

// operand and result width
`define OOO_DATA_W 16

// rename id width, 32 tags
`define OOO_RNID_W 5

// credit counter holds 0..ENTRY_SIZE
`define OOO_CREDIT_W ($clog2(`OOO_ENTRY_SIZE) + 1)

`endif

/* hw/ooo_pkg.sv */
`include "ooo_defines.svh"

package ooo_pkg;

  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_AND = 2'd2,
    OP_XOR = 2'd3
  } op_e;

  // tag view of an operand word, rnid sits in the low bits
  typedef struct packed {
    logic [`OOO_DATA_W-`OOO_RNID_W-1:0] pad;
    logic [`OOO_RNID_W-1:0]             rnid;
  } opnd_tag_t;

  typedef union packed {
    logic [`OOO_DATA_W-1:0] value;  // when ready
    opnd_tag_t              tag;    // while waiting
  } opnd_u;

  typedef struct packed {
    logic  ready;
    opnd_u opnd;
  } src_t;

  typedef struct packed {
    op_e                    op;
    src_t                   src1;
    src_t                   src2;
    logic [`OOO_RNID_W-1:0] rnid;
  } disp_t;

  typedef struct packed {
    op_e                    op;
    logic [`OOO_DATA_W-1:0] val1;
    logic [`OOO_DATA_W-1:0] val2;
    logic [`OOO_RNID_W-1:0] rnid;
  } issue_t;

endpackage

/* hw/result_if.sv */
`include "ooo_defines.svh"

// single broadcast result bus, one result per cycle
interface result_if;

  logic                   valid;
  logic [`OOO_RNID_W-1:0] rnid;
  logic [`OOO_DATA_W-1:0] value;
  logic                   lane;   // producing lane

  modport drv (
    output valid,
    output rnid,
    output value,
    output lane
  );

  modport lsn (
    input valid,
    input rnid,
    input value,
    input lane
  );

endinterface

/* hw/wb_merge.sv */
`include "ooo_defines.svh"

module wb_merge
  import ooo_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_valid_0,
  input  logic [`OOO_RNID_W-1:0] i_rnid_0,
  input  logic [`OOO_DATA_W-1:0] i_value_0,
  input  logic                   i_valid_1,
  input  logic [`OOO_RNID_W-1:0] i_rnid_1,
  input  logic [`OOO_DATA_W-1:0] i_value_1,
  output logic                   o_grant_0,
  output logic                   o_grant_1,
  result_if.drv                  bus
);

  logic                   r_last;   // lane granted last time
  logic                   r_valid;
  logic                   r_lane;
  logic [`OOO_RNID_W-1:0] r_rnid;
  logic [`OOO_DATA_W-1:0] r_value;

  // on a tie the other lane wins
  assign o_grant_0 = i_valid_0 & (~i_valid_1 | r_last);
  assign o_grant_1 = i_valid_1 & (~i_valid_0 | ~r_last);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_last  <= 1'b1;
      r_valid <= 1'b0;
    end else begin
      r_valid <= o_grant_0 | o_grant_1;
      if (o_grant_0 | o_grant_1) begin
        r_last <= o_grant_1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_grant_0 | o_grant_1) begin
      r_lane  <= o_grant_1;
      r_rnid  <= o_grant_1 ? i_rnid_1 : i_rnid_0;
      r_value <= o_grant_1 ? i_value_1 : i_value_0;
    end
  end

  assign bus.valid = r_valid;
  assign bus.rnid  = r_rnid;
  assign bus.value = r_value;
  assign bus.lane  = r_lane;

endmodule

/* tb/sched_checker.sv */
`include "ooo_defines.svh"

module sched_checker (
  input  logic                   i_clk,
  input  logic                   i_disp_valid_0,
  input  logic                   i_disp_valid_1,
  input  logic                   i_credit_0,
  input  logic                   i_credit_1,
  input  logic                   i_done_valid,
  input  logic [`OOO_RNID_W-1:0] i_done_rnid,
  input  logic [`OOO_DATA_W-1:0] i_done_value,
  input  logic                   i_done_lane,
  output logic                   o_busy
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NTAG = 1 << `OOO_RNID_W;

  string                  test_name = "none";
  bit                     ordered;
  bit                     pend [NTAG];
  logic [`OOO_DATA_W-1:0] exp_value [NTAG];
  bit                     exp_lane [NTAG];
  int                     exp_seq [NTAG];    // position within its lane
  int                     n_exp [2];
  int                     n_done [2];
  int                     n_pend;
  int                     disp_cnt [2];
  int                     ret_cnt [2];
  int                     done_cnt [2];      // results seen per lane
  bit                     seen_disp;
  int                     test_errs;
  int                     errors;
  int                     tests_run;
  int                     tests_bad;

  assign o_busy = (n_pend != 0);

  task automatic log_error(input string msg);
    $display("%s", msg);
    test_errs++;
    errors++;
  endtask

  task automatic start_test(input string name, input bit ord);
    test_name = name;
    ordered   = ord;
    test_errs = 0;
    n_exp     = '{0, 0};
    n_done    = '{0, 0};
  endtask

  task automatic add_expect(input int rnid, input int value, input int lane);
    pend[rnid]      = 1'b1;
    exp_value[rnid] = value[`OOO_DATA_W-1:0];
    exp_lane[rnid]  = lane[0];
    exp_seq[rnid]   = n_exp[lane];
    n_exp[lane]++;
    n_pend++;
  endtask

  task automatic check_done();
    int r;
    int l;
    r = i_done_rnid;
    l = i_done_lane;
    if (!pend[r]) begin
      log_error($sformatf("test %s: rnid %0d completed but was not expected or already done",
                          test_name, r));
    end else begin
      pend[r] = 1'b0;
      n_pend--;
      done_cnt[l]++;
      // the credit leaves the cycle after issue, ahead of the result
      if (done_cnt[l] > ret_cnt[l]) begin
        log_error($sformatf("test %s: lane %0d delivered rnid %0d before returning its credit",
                            test_name, l, r));
      end
      if (i_done_value !== exp_value[r]) begin
        log_error($sformatf("mismatch test %s rnid %0d expected %h actual %h",
                            test_name, r, exp_value[r], i_done_value));
      end
      if (i_done_lane !== exp_lane[r]) begin
        log_error($sformatf("mismatch test %s rnid %0d lane expected %0d actual %0d",
                            test_name, r, exp_lane[r], i_done_lane));
      end
      if (ordered && exp_seq[r] != n_done[l]) begin
        log_error($sformatf("test %s: rnid %0d completed out of dispatch order in lane %0d",
                            test_name, r, l));
      end
      n_done[l]++;
    end
  endtask

  // sample mid-cycle where inputs and outputs are settled
  always @(negedge i_clk) begin
    if (!seen_disp && (i_done_valid === 1'b1 || i_credit_0 === 1'b1 || i_credit_1 === 1'b1)) begin
      log_error("done or credit output went high before the first dispatch");
    end
    if (i_disp_valid_0 === 1'b1) begin
      seen_disp = 1'b1;
      disp_cnt[0]++;
    end
    if (i_disp_valid_1 === 1'b1) begin
      seen_disp = 1'b1;
      disp_cnt[1]++;
    end
    if (i_credit_0 === 1'b1) ret_cnt[0]++;
    if (i_credit_1 === 1'b1) ret_cnt[1]++;
    for (int l = 0; l < 2; l++) begin
      if (ret_cnt[l] > disp_cnt[l]) begin
        log_error($sformatf("lane %0d returned a credit with no entry outstanding", l));
        ret_cnt[l] = disp_cnt[l];
      end
    end
    if (i_done_valid === 1'b1) check_done();
  end

  task automatic end_test();
    for (int r = 0; r < NTAG; r++) begin
      if (pend[r]) begin
        log_error($sformatf("test %s: no result arrived for rnid %0d", test_name, r));
        pend[r] = 1'b0;
      end
    end
    n_pend = 0;
    for (int l = 0; l < 2; l++) begin
      if (disp_cnt[l] != ret_cnt[l]) begin
        log_error($sformatf("test %s: lane %0d returned %0d credits for %0d dispatches",
                            test_name, l, ret_cnt[l], disp_cnt[l]));
      end
    end
    tests_run++;
    if (test_errs == 0) begin
      $display("test %s: pass", test_name);
    end else begin
      tests_bad++;
      $display("test %s: fail with %0d errors", test_name, test_errs);
    end
  endtask

  task automatic report(output int errs);
    $display("tests %0d passed %0d failed %0d errors %0d",
             tests_run, tests_run - tests_bad, tests_bad, errors);
    errs = errors;
  endtask

endmodule

/* tb/sched_testdata.txt */
# T name ordered | D lane op rdy1 opnd1 rdy2 opnd2 rnid | E rnid value lane
# op is 0 add 1 sub 2 and 3 xor and hex opnd holds a tag when its rdy is 0

T indep 0
D 0 0 1 1234 1 0111 1
D 1 1 1 0001 1 0002 2
D 0 2 1 f0f0 1 3c3c 3
D 1 3 1 aaaa 1 5a5a 4
E 1 1345 0
E 2 ffff 1
E 3 3030 0
E 4 f0f0 1

T chain 0
D 1 2 0 0007 0 0008 9
D 0 0 0 0005 1 0010 7
D 1 3 0 0005 1 0f0f 8
D 0 1 1 0100 1 0001 5
E 5 00ff 0
E 7 010f 0
E 8 0ff0 1
E 9 0100 1

T fill 1
D 0 0 0 0014 1 0001 11
D 0 0 0 0014 1 0002 12
D 0 0 0 0014 1 0003 13
D 0 0 0 0014 1 0004 14
D 0 0 0 0014 1 0005 15
D 0 0 0 0014 1 0006 16
D 0 0 0 0014 1 0007 17
D 0 0 0 0014 1 0008 18
D 1 0 1 0005 1 0005 20
D 0 3 1 ffff 1 00ff 19
E 11 000b 0
E 12 000c 0
E 13 000d 0
E 14 000e 0
E 15 000f 0
E 16 0010 0
E 17 0011 0
E 18 0012 0
E 19 ff00 0
E 20 000a 1

/* tb/tb_top.sv */
`include "ooo_defines.svh"

module tb_top
  import ooo_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 10;

  logic                   clk;
  logic                   rst_n;
  logic                   disp_valid_0;
  logic                   disp_valid_1;
  disp_t                  disp_0;
  disp_t                  disp_1;
  logic                   credit_0;
  logic                   credit_1;
  logic                   done_valid;
  logic [`OOO_RNID_W-1:0] done_rnid;
  logic [`OOO_DATA_W-1:0] done_value;
  logic                   done_lane;
  logic                   chk_busy;

  string t_name [$];
  bit    t_ord [$];
  int    t_dfirst [$];   // one extra entry closes the last test
  int    t_efirst [$];
  disp_t d_word [$];
  int    d_lane [$];
  int    e_rnid [$];
  int    e_value [$];
  int    e_lane [$];

  int used [2];       // credits spent per lane
  int returned [2];
  int seed = 48;
  int n_disp;
  bit loaded;

  ooo_core_top ooo_core_top_i (
    .i_clk(clk), .i_rst_n(rst_n),
    .i_disp_valid_0(disp_valid_0), .i_disp_0(disp_0),
    .i_disp_valid_1(disp_valid_1), .i_disp_1(disp_1),
    .o_credit_0(credit_0), .o_credit_1(credit_1),
    .o_done_valid(done_valid), .o_done_rnid(done_rnid),
    .o_done_value(done_value), .o_done_lane(done_lane)
  );

  sched_checker u_checker (
    .i_clk(clk),
    .i_disp_valid_0(disp_valid_0), .i_disp_valid_1(disp_valid_1),
    .i_credit_0(credit_0), .i_credit_1(credit_1),
    .i_done_valid(done_valid), .i_done_rnid(done_rnid),
    .i_done_value(done_value), .i_done_lane(done_lane),
    .o_busy(chk_busy)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(negedge clk) begin
    if (credit_0 === 1'b1) returned[0]++;
    if (credit_1 === 1'b1) returned[1]++;
  end

  function automatic src_t make_src(int rdy, int v);
    src_t s;
    s.ready = (rdy != 0);
    if (rdy != 0) begin
      s.opnd.value = v[`OOO_DATA_W-1:0];
    end else begin
      s.opnd.tag.pad  = '0;
      s.opnd.tag.rnid = v[`OOO_RNID_W-1:0];
    end
    return s;
  endfunction

  task automatic load_tests(output bit ok);
    int    fd;
    int    n;
    int    lane;
    int    op;
    int    r1;
    int    r2;
    int    v1;
    int    v2;
    int    rnid;
    bit    bad;
    string line;
    string kind;
    string name;
    disp_t d;
    ok  = 1'b0;
    bad = 1'b0;
    fd  = $fopen("tb/sched_testdata.txt", "r");
    if (fd != 0) begin
      while ($fgets(line, fd) > 0) begin
        n = $sscanf(line, "%s", kind);
        if (n == 1 && kind == "T") begin
          n = $sscanf(line, "T %s %d", name, op);
          t_name.push_back(name);
          t_ord.push_back(op != 0);
          t_dfirst.push_back(d_word.size());
          t_efirst.push_back(e_rnid.size());
          bad = bad | (n != 2);
        end else if (n == 1 && kind == "D") begin
          n = $sscanf(line, "D %d %d %d %h %d %h %d", lane, op, r1, v1, r2, v2, rnid);
          d.op   = op_e'(op);
          d.src1 = make_src(r1, v1);
          d.src2 = make_src(r2, v2);
          d.rnid = rnid[`OOO_RNID_W-1:0];
          d_word.push_back(d);
          d_lane.push_back(lane);
          bad = bad | (n != 7) | (t_name.size() == 0);
        end else if (n == 1 && kind == "E") begin
          n = $sscanf(line, "E %d %h %d", rnid, v1, lane);
          e_rnid.push_back(rnid);
          e_value.push_back(v1);
          e_lane.push_back(lane);
          bad = bad | (n != 3) | (t_name.size() == 0);
        end
      end
      $fclose(fd);
      t_dfirst.push_back(d_word.size());
      t_efirst.push_back(e_rnid.size());
      ok = !bad && (t_name.size() > 0);
    end
  endtask

  // enters and returns 1 ns after a rising edge
  task automatic dispatch(input int k);
    int lane;
    lane = d_lane[k];
    while (`OOO_ENTRY_SIZE - used[lane] + returned[lane] <= 0) begin
      @(posedge clk);
      #1;
    end
    if (lane == 0) begin
      disp_0       = d_word[k];
      disp_valid_0 = 1'b1;
    end else begin
      disp_1       = d_word[k];
      disp_valid_1 = 1'b1;
    end
    used[lane]++;
    @(posedge clk);
    #1;
    disp_valid_0 = 1'b0;
    disp_valid_1 = 1'b0;
  endtask

  initial begin
    int limit;
    wait (loaded);
    limit = RESET_CYCLES + 200 * n_disp;
    repeat (limit) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    bit ok;
    int gap;
    int nd;
    int errs;
    rst_n        = 1'b0;
    disp_valid_0 = 1'b0;
    disp_valid_1 = 1'b0;
    disp_0       = '0;
    disp_1       = '0;
    load_tests(ok);
    n_disp = d_word.size();
    loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    if (!ok) $display("test data file is missing or has a malformed line");
    for (int ti = 0; ok && ti < t_name.size(); ti++) begin
      u_checker.start_test(t_name[ti], t_ord[ti]);
      for (int j = t_efirst[ti]; j < t_efirst[ti + 1]; j++) begin
        u_checker.add_expect(e_rnid[j], e_value[j], e_lane[j]);
      end
      for (int k = t_dfirst[ti]; k < t_dfirst[ti + 1]; k++) begin
        dispatch(k);
        gap = $unsigned($random(seed)) % 3;
        repeat (gap) begin
          @(posedge clk);
          #1;
        end
      end
      nd = t_dfirst[ti + 1] - t_dfirst[ti];
      for (int c = 0; c < 40 * nd + 20 && chk_busy; c++) begin
        @(posedge clk);
        #1;
      end
      repeat (4) begin  // late duplicates and credits
        @(posedge clk);
        #1;
      end
      u_checker.end_test();
    end
    u_checker.report(errs);
    if (ok && errs == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
